/* list.f */
+incdir+common
common/rhPkg.sv
hw/rhBusDecode.sv
hw/rhCommand.sv
hw/rhInterrupt.sv
hw/rhController.sv
testbench/rhController_checker.sv
testbench/rhControllerTb.sv

/* testbench/rhControllerTb.sv */
// RH11 controller testbench
`default_nettype none

`include "rh_consts.svh"

module rhControllerTb;

   timeunit 1ns;
   timeprecision 1ps;

   // Expected outcome of one GO command
   typedef struct packed
   {
      rhPkg::rhWord er;
      logic         rdy;
      logic         irq;
   } expectedResult;

   logic            clk;
   logic            rst;
   logic            devReset;
   logic            wbCyc;
   logic            wbStb;
   logic            wbWe;
   rhPkg::rhRegAddr wbAdr;
   rhPkg::rhByteSel wbSel;
   rhPkg::rhWord    wbDatI;
   rhPkg::rhWord    wbDatO;
   logic            wbAck;
   logic            irqAck;
   logic            irq;

   // Observations waiting for the compare process
   string           checkName[$];
   time             checkTime[$];
   rhPkg::rhWord    checkExp[$];
   rhPkg::rhWord    checkGot[$];

   int errorCount = 0;
   int checkCount = 0;
   int testsRun = 0;
   int testsFailed = 0;
   int testStartErrors = 0;
   int assertFailsSeen = 0;

   rhController DUT
   (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .wbCyc    (wbCyc),
      .wbStb    (wbStb),
      .wbWe     (wbWe),
      .wbAdr    (wbAdr),
      .wbSel    (wbSel),
      .wbDatI   (wbDatI),
      .wbDatO   (wbDatO),
      .wbAck    (wbAck),
      .irqAck   (irqAck),
      .irq      (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reference model and compare
   //////////////////////////////////////////////////

   // RH11 rules for a GO from the given state
   function automatic expectedResult refResult(input rhPkg::rhFunc func, input logic ieBit,
                                               input logic wasBusy);
      expectedResult res;
      logic legal;
      legal = (func == `RH_FUNC_NOP) || (func == `RH_FUNC_SEEK) ||
              (func == `RH_FUNC_READ) || (func == `RH_FUNC_WRITE);
      res.er = '0;
      res.rdy = 1'b1;
      if (wasBusy)
      begin
         // Rejected GO flags RMR and SC requests once RDY is back
         res.er[`RH_ER_RMR] = 1'b1;
         res.irq = 1'b1;
      end
      else if (!legal)
      begin
         // SC request ignores IE
         res.er[`RH_ER_ILF] = 1'b1;
         res.irq = 1'b1;
      end
      else
         res.irq = ieBit;
      return res;
   endfunction

   // CS1 data for a GO command
   function automatic rhPkg::rhWord goWord(input rhPkg::rhFunc func, input logic ieBit);
      rhPkg::rhWord word;
      word = '0;
      word[`RH_CS1_GO] = 1'b1;
      word[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO] = func;
      word[`RH_CS1_IE] = ieBit;
      return word;
   endfunction

   task automatic expectValue(input string name, input rhPkg::rhWord expVal,
                              input rhPkg::rhWord gotVal);
      checkName.push_back(name);
      checkTime.push_back($time);
      checkExp.push_back(expVal);
      checkGot.push_back(gotVal);
   endtask

   always @(posedge clk)
   begin : compareResults
      string        name;
      time          seenAt;
      rhPkg::rhWord expVal;
      rhPkg::rhWord gotVal;
      while (checkGot.size() > 0)
      begin
         name = checkName.pop_front();
         seenAt = checkTime.pop_front();
         expVal = checkExp.pop_front();
         gotVal = checkGot.pop_front();
         checkCount++;
         if (gotVal !== expVal)
         begin
            $display("FAIL t=%0t %s expected=%h got=%h", seenAt, name, expVal, gotVal);
            errorCount++;
         end
      end
   end

   //////////////////////////////////////////////////
   // Bus and wait tasks
   //////////////////////////////////////////////////

   // One Wishbone access that returns after the commit edge
   task automatic busAccess(input logic we, input rhPkg::rhRegAddr adr,
                            input rhPkg::rhByteSel sel, input rhPkg::rhWord data,
                            output rhPkg::rhWord readData);
      int waited;
      waited = 0;
      readData = '0;
      wbCyc = 1'b1;
      wbStb = 1'b1;
      wbWe = we;
      wbAdr = adr;
      wbSel = sel;
      wbDatI = data;
      do
      begin
         @(posedge clk);
         #2;
         waited++;
      end
      while (!wbAck && waited < 8);
      if (!wbAck)
      begin
         $display("ERROR no acknowledge for access to address %0d at t=%0t", adr, $time);
         errorCount++;
      end
      else
         readData = wbDatO;
      // Strobe held through the ack cycle
      @(posedge clk);
      #2;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
   endtask

   // Poll CS1 until RDY is back
   task automatic waitReady();
      rhPkg::rhWord cs1;
      int tries;
      tries = 0;
      cs1 = '0;
      while (!cs1[`RH_CS1_RDY] && tries < 20)
      begin
         busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, cs1);
         tries++;
      end
      if (!cs1[`RH_CS1_RDY])
      begin
         $display("ERROR RDY did not return within %0d reads at t=%0t", tries, $time);
         errorCount++;
      end
   endtask

   task automatic waitIrq(input logic level);
      int cycles;
      cycles = 0;
      while (irq !== level && cycles < 30)
      begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (irq !== level)
      begin
         $display("ERROR irq did not reach %b within %0d cycles at t=%0t", level, cycles, $time);
         errorCount++;
      end
   endtask

   // Watch irq for a window of cycles
   task automatic holdIrqLow(input int cycles);
      for (int i = 0; i < cycles; i++)
      begin
         expectValue("irq", 16'h0000, {15'b0, irq});
         @(posedge clk);
         #2;
      end
   endtask

   task automatic pulseAck();
      irqAck = 1'b1;
      @(posedge clk);
      #2;
      irqAck = 1'b0;
   endtask

   // Wait for completion and compare ER, RDY and irq with the model
   task automatic checkOutcome(input string tag, input expectedResult exp);
      rhPkg::rhWord cs1;
      rhPkg::rhWord er;
      waitReady();
      if (exp.irq)
         waitIrq(1'b1);
      busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, cs1);
      busAccess(1'b0, `RH_ADDR_ER, 2'b11, '0, er);
      expectValue({tag, " er"}, exp.er, er);
      expectValue({tag, " rdy"}, {15'b0, exp.rdy}, {15'b0, cs1[`RH_CS1_RDY]});
      expectValue({tag, " irq"}, {15'b0, exp.irq}, {15'b0, irq});
   endtask

   task automatic drainChecks();
      int cycles;
      cycles = 0;
      while (checkGot.size() > 0 && cycles < 4)
      begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (checkGot.size() > 0)
      begin
         $display("ERROR queued checks were never compared");
         errorCount++;
      end
   endtask

   task automatic finishTest(input string name);
      drainChecks();
      // Bound checker failures since the previous test
      errorCount += DUT.busChecks.failCount - assertFailsSeen;
      assertFailsSeen = DUT.busChecks.failCount;
      testsRun++;
      if (errorCount == testStartErrors)
         $display("[%0t] %s: ok", $time, name);
      else
      begin
         testsFailed++;
         $display("[%0t] %s: %0d errors", $time, name, errorCount - testStartErrors);
      end
      testStartErrors = errorCount;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin : mainSequence
      rhPkg::rhWord  rdData;
      rhPkg::rhFunc  func;
      rhPkg::rhFunc  legalCodes[4];
      logic          ieBit;
      rst = 1'b1;
      devReset = 1'b0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      wbAdr = '0;
      wbSel = '0;
      wbDatI = '0;
      irqAck = 1'b0;
      void'($urandom(32'h4447));
      legalCodes = '{`RH_FUNC_NOP, `RH_FUNC_SEEK, `RH_FUNC_READ, `RH_FUNC_WRITE};
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      // Only RDY set after reset
      busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, rdData);
      expectValue("cs1", 16'h0080, rdData);
      busAccess(1'b0, `RH_ADDR_CS2, 2'b11, '0, rdData);
      expectValue("cs2", 16'h0000, rdData);
      busAccess(1'b0, `RH_ADDR_ER, 2'b11, '0, rdData);
      expectValue("er", 16'h0000, rdData);
      expectValue("irq", 16'h0000, {15'b0, irq});
      finishTest("reset values");

      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(`RH_FUNC_SEEK, 1'b0), rdData);
      busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, rdData);
      expectValue("cs1 rdy busy", 16'h0000, {15'b0, rdData[`RH_CS1_RDY]});
      checkOutcome("seek", refResult(`RH_FUNC_SEEK, 1'b0, 1'b0));
      holdIrqLow(3);
      finishTest("command without interrupt");

      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(`RH_FUNC_READ, 1'b1), rdData);
      checkOutcome("read", refResult(`RH_FUNC_READ, 1'b1, 1'b0));
      pulseAck();
      holdIrqLow(4);
      finishTest("completion interrupt");

      // RDY and IE written together while idle
      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, 16'h00c0, rdData);
      expectValue("irq low byte", 16'h0001, {15'b0, irq});
      pulseAck();
      expectValue("irq after ack", 16'h0000, {15'b0, irq});
      busAccess(1'b1, `RH_ADDR_CS1, 2'b10, 16'h00c0, rdData);
      holdIrqLow(3);
      finishTest("write-triggered interrupt");

      // Code 1 is not in the legal set
      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(5'd1, 1'b0), rdData);
      busAccess(1'b0, `RH_ADDR_ER, 2'b11, '0, rdData);
      expectValue("er ilf", 16'h0001, rdData);
      busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, rdData);
      expectValue("cs1 sc", 16'h0001, {15'b0, rdData[`RH_CS1_SC]});
      expectValue("irq sc", 16'h0001, {15'b0, irq});
      pulseAck();
      expectValue("irq sc after ack", 16'h0001, {15'b0, irq});
      // Second GO lands while the first runs
      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(`RH_FUNC_NOP, 1'b1), rdData);
      busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(`RH_FUNC_NOP, 1'b1), rdData);
      checkOutcome("rmr", refResult(`RH_FUNC_NOP, 1'b1, 1'b1));
      busAccess(1'b1, `RH_ADDR_CS2, 2'b01, 16'h0020, rdData);
      busAccess(1'b0, `RH_ADDR_CS1, 2'b11, '0, rdData);
      expectValue("cs1 after clr", 16'h0080, rdData);
      busAccess(1'b0, `RH_ADDR_ER, 2'b11, '0, rdData);
      expectValue("er after clr", 16'h0000, rdData);
      expectValue("irq after clr", 16'h0000, {15'b0, irq});
      finishTest("errors and SC");

      for (int i = 0; i < 12; i++)
      begin
         // Clean controller state before each command
         busAccess(1'b1, `RH_ADDR_CS2, 2'b01, 16'h0020, rdData);
         if ($urandom % 2)
            func = legalCodes[$urandom % 4];
         else
            func = rhPkg::rhFunc'($urandom % 32);
         ieBit = 1'($urandom % 2);
         busAccess(1'b1, `RH_ADDR_CS1, 2'b01, goWord(func, ieBit), rdData);
         checkOutcome($sformatf("cmd %0d func %0d ie %0d", i, func, ieBit),
                      refResult(func, ieBit, 1'b0));
      end
      finishTest("random commands");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               testsRun, testsFailed, checkCount, errorCount);
      if (errorCount == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/rhController_checker.sv */
// RH11 controller assertions
`default_nettype none

module rhController_checker
(
   input wire clk,
   input wire rst,
   input wire wbCyc,
   input wire wbStb,
   input wire wbAck,
   input wire cs1Write,
   input wire rdy,
   input wire irq
);

   timeunit 1ns;
   timeprecision 1ps;

   // Assertion failures seen so far
   int failCount = 0;

   //////////////////////////////////////////////////
   // Wishbone acknowledge
   //////////////////////////////////////////////////

   // Ack only inside an active cycle
   ackInCycle: assert property (@(posedge clk) disable iff (rst) wbAck |-> (wbCyc && wbStb))
      else
      begin
         failCount++;
         $error("wbAck high without wbCyc and wbStb");
      end

   // Single-cycle acknowledge
   ackSingle: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbAck)
      else
      begin
         failCount++;
         $error("wbAck high for two cycles in a row");
      end

   //////////////////////////////////////////////////
   // Interrupt and status
   //////////////////////////////////////////////////

   // Reset leaves no request behind
   irqAfterReset: assert property (@(posedge clk) rst |=> !irq)
      else
      begin
         failCount++;
         $error("irq high in the cycle after reset");
      end

   // Only a committed CS1 write starts an operation
   rdyFallCause: assert property (@(posedge clk) disable iff (rst) $fell(rdy) |-> $past(cs1Write))
      else
      begin
         failCount++;
         $error("rdy fell without a CS1 write");
      end

endmodule

bind rhController rhController_checker busChecks
(
   .clk      (clk),
   .rst      (rst),
   .wbCyc    (wbCyc),
   .wbStb    (wbStb),
   .wbAck    (wbAck),
   .cs1Write (cs1Write),
   .rdy      (rdy),
   .irq      (irq)
);

`default_nettype wire

/* hw/rhController.sv */
// RH11 controller top level
`default_nettype none

module rhController
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   devReset,
   input  wire                   wbCyc,
   input  wire                   wbStb,
   input  wire                   wbWe,
   input  wire rhPkg::rhRegAddr  wbAdr,
   input  wire rhPkg::rhByteSel  wbSel,
   input  wire rhPkg::rhWord     wbDatI,
   output rhPkg::rhWord          wbDatO,
   output logic                  wbAck,
   input  wire                   irqAck,
   output logic                  irq
);

   // Decode to command and interrupt
   logic         cs1Write;
   logic         cs2Write;
   logic         lowByte;
   rhPkg::rhWord writeData;

   // Register read values back to decode
   rhPkg::rhWord cs1Value;
   rhPkg::rhWord cs2Value;
   rhPkg::rhWord erValue;

   // Status into the interrupt logic
   logic rdy;
   logic ie;
   logic sc;
   logic clr;

   //////////////////////////////////////////////////
   // Bus slave
   //////////////////////////////////////////////////

   rhBusDecode decode
   (
      .clk       (clk),
      .rst       (rst),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbSel     (wbSel),
      .wbDatI    (wbDatI),
      .wbDatO    (wbDatO),
      .wbAck     (wbAck),
      .cs1Write  (cs1Write),
      .cs2Write  (cs2Write),
      .lowByte   (lowByte),
      .writeData (writeData),
      .cs1Value  (cs1Value),
      .cs2Value  (cs2Value),
      .erValue   (erValue)
   );

   //////////////////////////////////////////////////
   // Registers and sequencer
   //////////////////////////////////////////////////

   rhCommand execute
   (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .cs1Write  (cs1Write),
      .cs2Write  (cs2Write),
      .lowByte   (lowByte),
      .writeData (writeData),
      .cs1Value  (cs1Value),
      .cs2Value  (cs2Value),
      .erValue   (erValue),
      .rdy       (rdy),
      .ie        (ie),
      .sc        (sc),
      .clr       (clr)
   );

   //////////////////////////////////////////////////
   // Interrupt
   //////////////////////////////////////////////////

   rhInterrupt result
   (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .cs1Write  (cs1Write),
      .lowByte   (lowByte),
      .writeData (writeData),
      .rdy       (rdy),
      .ie        (ie),
      .sc        (sc),
      .clr       (clr),
      .irqAck    (irqAck),
      .irq       (irq)
   );

endmodule

`default_nettype wire

/* hw/rhInterrupt.sv */
// RH11 interrupt logic
`default_nettype none

`include "rh_consts.svh"

module rhInterrupt
(
   input  wire                clk,
   input  wire                rst,
   input  wire                devReset,
   input  wire                cs1Write,
   input  wire                lowByte,
   input  wire rhPkg::rhWord  writeData,
   input  wire                rdy,
   input  wire                ie,
   input  wire                sc,
   input  wire                clr,
   input  wire                irqAck,
   output logic               irq
);

   logic lastRdy;
   logic irqFf;
   logic rdyRise;
   logic writeSet;

   //////////////////////////////////////////////////
   // RDY edge detect
   //////////////////////////////////////////////////

   // RDY comes out of reset set, so start high
   always_ff @(posedge clk)
   begin
      if (rst)
         lastRdy <= 1'b1;
      else
         lastRdy <= rdy;
   end

   assign rdyRise = rdy & ~lastRdy;

   //////////////////////////////////////////////////
   // Interrupt flip-flop
   //////////////////////////////////////////////////

   // Software can force an interrupt by writing RDY and IE together
   assign writeSet = cs1Write & lowByte & writeData[`RH_CS1_RDY] & writeData[`RH_CS1_IE];

   always_ff @(posedge clk)
   begin
      // Clear has priority over any set source
      if (rst | devReset | clr | irqAck)
         irqFf <= 1'b0;
      else if ((rdyRise & ie) | writeSet)
         irqFf <= 1'b1;
   end

   // Error request ignores IE and is not acknowledged away
   assign irq = irqFf | (sc & rdy);

endmodule

`default_nettype wire

/* hw/rhCommand.sv */
// RH11 command registers and sequencer
`default_nettype none

`include "rh_consts.svh"

module rhCommand
(
   input  wire                clk,
   input  wire                rst,
   input  wire                devReset,
   input  wire                cs1Write,
   input  wire                cs2Write,
   input  wire                lowByte,
   input  wire rhPkg::rhWord  writeData,
   output rhPkg::rhWord       cs1Value,
   output rhPkg::rhWord       cs2Value,
   output rhPkg::rhWord       erValue,
   output logic               rdy,
   output logic               ie,
   output logic               sc,
   output logic               clr
);

   localparam int cntWidth = $clog2(`RH_OP_CYCLES);

   rhPkg::cmdState      state;
   rhPkg::rhFunc        funcQ;
   rhPkg::rhFunc        funcIn;
   logic [cntWidth-1:0] opCount;
   logic                ieQ;
   logic                ilfQ;
   logic                rmrQ;
   logic                goWrite;
   logic                funcLegal;
   logic                busy;

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   assign funcIn  = writeData[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO];
   assign goWrite = cs1Write & lowByte & writeData[`RH_CS1_GO];
   assign busy    = (state == rhPkg::Busy);

   // One-shot controller clear from the CS2 write strobe
   assign clr = cs2Write & lowByte & writeData[`RH_CS2_CLR];

   // Legal function check
   always_comb
   begin
      case (funcIn)
         `RH_FUNC_NOP,
         `RH_FUNC_SEEK,
         `RH_FUNC_READ,
         `RH_FUNC_WRITE: funcLegal = 1'b1;
         default:        funcLegal = 1'b0;
      endcase
   end

   //////////////////////////////////////////////////
   // Busy sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | devReset | clr)
      begin
         // Clear aborts any operation in progress
         state   <= rhPkg::Idle;
         opCount <= '0;
      end
      else
      begin
         case (state)
            rhPkg::Idle:
            begin
               if (goWrite && funcLegal)
               begin
                  state   <= rhPkg::Busy;
                  opCount <= cntWidth'(`RH_OP_CYCLES - 1);
               end
            end
            rhPkg::Busy:
            begin
               // RDY returns when the count runs out
               if (opCount == '0)
                  state <= rhPkg::Idle;
               else
                  opCount <= opCount - 1'b1;
            end
            default:
               state <= rhPkg::Idle;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // CS1 fields and error flags
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | devReset | clr)
      begin
         ieQ   <= 1'b0;
         funcQ <= '0;
         ilfQ  <= 1'b0;
         rmrQ  <= 1'b0;
      end
      else
      begin
         if (cs1Write && lowByte)
         begin
            // Function code frozen while the drive is busy
            if (!busy)
               funcQ <= funcIn;
            // GO while busy changes nothing else
            if (!(goWrite && busy))
               ieQ <= writeData[`RH_CS1_IE];
         end
         if (goWrite)
         begin
            if (busy)
               rmrQ <= 1'b1;
            else
            begin
               // Accepted GO starts with fresh error state
               ilfQ <= ~funcLegal;
               rmrQ <= 1'b0;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Register read values
   //////////////////////////////////////////////////

   assign rdy = ~busy;
   assign ie  = ieQ;
   // Any error raises special conditions
   assign sc  = ilfQ | rmrQ;

   always_comb
   begin
      cs1Value = '0;
      cs1Value[`RH_CS1_GO] = busy;   // GO reads back set while running
      cs1Value[`RH_CS1_FUNC_HI:`RH_CS1_FUNC_LO] = funcQ;
      cs1Value[`RH_CS1_IE] = ieQ;
      cs1Value[`RH_CS1_RDY] = rdy;
      cs1Value[`RH_CS1_SC] = sc;
   end

   // CLR is write-only
   assign cs2Value = '0;

   always_comb
   begin
      erValue = '0;
      erValue[`RH_ER_ILF] = ilfQ;
      erValue[`RH_ER_RMR] = rmrQ;
   end

endmodule

`default_nettype wire

/* hw/rhBusDecode.sv */
// RH11 Wishbone slave decode
`default_nettype none

`include "rh_consts.svh"

module rhBusDecode
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   wbCyc,
   input  wire                   wbStb,
   input  wire                   wbWe,
   input  wire rhPkg::rhRegAddr  wbAdr,
   input  wire rhPkg::rhByteSel  wbSel,
   input  wire rhPkg::rhWord     wbDatI,
   output rhPkg::rhWord          wbDatO,
   output logic                  wbAck,
   output logic                  cs1Write,
   output logic                  cs2Write,
   output logic                  lowByte,
   output rhPkg::rhWord          writeData,
   input  wire rhPkg::rhWord     cs1Value,
   input  wire rhPkg::rhWord     cs2Value,
   input  wire rhPkg::rhWord     erValue
);

   //////////////////////////////////////////////////
   // Access capture
   //////////////////////////////////////////////////

   // New access seen on the bus, not yet acknowledged
   logic request;

   // Access fields held for the acknowledge cycle
   rhPkg::rhRegAddr adrQ;
   rhPkg::rhByteSel selQ;
   rhPkg::rhWord    datQ;
   logic            weQ;

   assign request = wbCyc & wbStb & ~wbAck;

   // Single-cycle acknowledge
   always_ff @(posedge clk)
   begin
      if (rst)
         wbAck <= 1'b0;
      else
         wbAck <= request;
   end

   // Payload latches
   always_ff @(posedge clk)
   begin
      if (request)
      begin
         adrQ <= wbAdr;
         selQ <= wbSel;
         datQ <= wbDatI;
         weQ  <= wbWe;
      end
   end

   //////////////////////////////////////////////////
   // Write strobes
   //////////////////////////////////////////////////

   // Write with at least one byte lane enabled
   logic writeAck;

   assign writeAck  = wbAck & weQ & (|selQ);
   assign cs1Write  = writeAck & (adrQ == `RH_ADDR_CS1);
   assign cs2Write  = writeAck & (adrQ == `RH_ADDR_CS2);

   // All writable control bits live in the low byte
   assign lowByte   = selQ[0];
   assign writeData = datQ;

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////

   always_comb
   begin
      wbDatO = '0;
      // Only drive data in a read acknowledge
      if (wbAck && !weQ)
      begin
         case (adrQ)
            `RH_ADDR_CS1: wbDatO = cs1Value;
            `RH_ADDR_CS2: wbDatO = cs2Value;
            `RH_ADDR_ER:  wbDatO = erValue;
            // Address 3 is unused and reads zero
            default:      wbDatO = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* common/rhPkg.sv */
// RH11 controller shared types
`default_nettype none

package rhPkg;

   //////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////

   // Register and bus data word
   typedef logic [15:0] rhWord;

   // Register word address
   typedef logic [1:0] rhRegAddr;

   // Function code field of CS1
   typedef logic [4:0] rhFunc;

   // Wishbone byte lane select
   typedef logic [1:0] rhByteSel;

   //////////////////////////////////////////////////
   // Sequencer state
   //////////////////////////////////////////////////

   // Idle means RDY set, Busy means a drive operation is running
   typedef enum logic
   {
      Idle,
      Busy
   } cmdState;

endpackage

`default_nettype wire

/* common/rh_consts.svh */
// RH11 register map constants
`ifndef RH_CONSTS_SVH
`define RH_CONSTS_SVH

//////////////////////////////////////////////////
// Register word addresses
//////////////////////////////////////////////////

`define RH_ADDR_CS1     2'd0
`define RH_ADDR_CS2     2'd1
`define RH_ADDR_ER      2'd2

//////////////////////////////////////////////////
// Bit positions
//////////////////////////////////////////////////

// CS1 fields
`define RH_CS1_GO       0
`define RH_CS1_FUNC_LO  1
`define RH_CS1_FUNC_HI  5
`define RH_CS1_IE       6
`define RH_CS1_RDY      7
`define RH_CS1_SC       15

// CS2 controller clear
`define RH_CS2_CLR      5

// ER flags
`define RH_ER_ILF       0
`define RH_ER_RMR       1

//////////////////////////////////////////////////
// Legal function codes and operation length
//////////////////////////////////////////////////

`define RH_FUNC_NOP     5'd0
`define RH_FUNC_SEEK    5'd2
`define RH_FUNC_READ    5'd28
`define RH_FUNC_WRITE   5'd24

// Simulated drive operation length in clock cycles
`define RH_OP_CYCLES    12

`endif
